// ==== compile.f ====
hw/alsPkg.sv
hw/sckGen.sv
hw/alsSampler.sv
hw/lightSmoother.sv
hw/lightMonitor.sv
hw/alsMonitorTop.sv
test/alsSensorModel.sv
test/tbAlsMonitor.sv

// ==== Makefile ====
SRCS := $(wildcard hw/*.sv test/*.sv)

obj_dir/VtbAlsMonitor: compile.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tbAlsMonitor -f compile.f

run: obj_dir/VtbAlsMonitor
	@out="$$(./obj_dir/VtbAlsMonitor)"; echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== test/tbAlsMonitor.sv ====
// testbench with clock, reset, sensor model, directed tests, compare tasks and report
`timescale 1ns/1ns

module tbAlsMonitor import alsPkg::*; ();

    localparam int LedCount  = 8;
    localparam int AvgShift  = 2;
    localparam int DarkOn    = 40;
    localparam int DarkOff   = 60;
    localparam int WaitLimit = 2000;

    logic                clk;
    logic                rstN;
    logic                cs;
    logic                sck;
    logic                sdo;
    sample_t             level;
    logic [LedCount-1:0] leds;
    logic                dark;
    sample_t             sensorValue;
    int                  riseCount = 0;
    int                  errors;
    int                  checks;
    int                  tests;
    logic [31:0]         rngState;
    // reference smoother and alarm
    int                  refAcc;
    logic                refPrimed;
    sample_t             refLevel;
    logic                refDark;
    sample_t             sampleSet [5] = '{8'h00, 8'h30, 8'h70, 8'hB0, 8'hFF};

    alsMonitorTop #(
        .QUERY_DELAY (4),
        .AVG_SHIFT   (AvgShift),
        .DARK_ON     (DarkOn),
        .DARK_OFF    (DarkOff),
        .LED_COUNT   (LedCount)
    ) DUT (.*);

    alsSensorModel sensor (.cs(cs), .sck(sck), .value(sensorValue), .sdo(sdo));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge sck) begin
        if (!cs) begin
            riseCount <= riseCount + 1;
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // number of lit leds is level scaled to the bar length
    function automatic logic [LedCount-1:0] thermoCode(input sample_t lvl);
        int lit;
        lit = (int'(lvl) * LedCount) / 256;
        return LedCount'((64'd1 << lit) - 64'd1);
    endfunction

    task automatic checkLevel(input string name, input sample_t expected, input sample_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s: expected %0d, actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkLeds(input string name, input logic [LedCount-1:0] expected,
                             input logic [LedCount-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s: expected %b, actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s: expected %b, actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic modelSample(input sample_t s);
        if (!refPrimed) begin
            refAcc = int'(s) << AvgShift;
        end else begin
            refAcc = refAcc - (refAcc >> AvgShift) + int'(s);
        end
        refPrimed = 1'b1;
        refLevel  = sample_t'(refAcc >> AvgShift);
        if (int'(refLevel) < DarkOn) begin
            refDark = 1'b1;
        end else if (int'(refLevel) >= DarkOff) begin
            refDark = 1'b0;
        end
    endtask

    // waits past the next frame end and a few pipeline cycles
    task automatic waitFrame();
        int   n;
        logic csPrev;
        logic seen;
        n      = 0;
        seen   = 1'b0;
        csPrev = cs;
        while (!seen && n < WaitLimit) begin
            @(posedge clk);
            #1;
            seen   = !csPrev && cs;
            csPrev = cs;
            n++;
        end
        if (!seen) begin
            errors++;
            $display("timeout: no frame ended within %0d clock cycles", WaitLimit);
        end else begin
            repeat (4) @(posedge clk);
            #1;
        end
    endtask

    task automatic runFrame(input sample_t v);
        sensorValue = v;
        waitFrame();
        modelSample(v);
        checkLevel("level", refLevel, level);
        checkLeds("leds", thermoCode(refLevel), leds);
        checkBit("dark", refDark, dark);
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        tests++;
        if (errors == errorsBefore) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errorsBefore);
        end
    endtask

    task automatic resetValuesTest();
        int e0;
        e0 = errors;
        checkBit("cs", 1'b1, cs);
        checkBit("sck", 1'b0, sck);
        checkLevel("level", 8'd0, level);
        checkLeds("leds", '0, leds);
        checkBit("dark", 1'b0, dark);
        reportTest("reset", e0);
    endtask

    task automatic frameFormatTest();
        int e0;
        int start;
        e0    = errors;
        start = riseCount;
        runFrame(8'hA5);
        if (riseCount - start != 18) begin
            errors++;
            $display("[ERROR] %0t ns sck rises: expected 18, actual %0d", $time, riseCount - start);
        end
        checkLevel("level", 8'hA5, level);
        reportTest("frame format", e0);
    endtask

    task automatic averagingTest();
        int e0;
        int dStart;
        e0     = errors;
        dStart = int'(refLevel) - 32;
        for (int i = 0; i < 6; i++) begin
            runFrame(8'h20);
        end
        checkBit("level converging", 1'b1, (int'(level) - 32 < dStart) && (level >= 8'h20));
        reportTest("averaging", e0);
    endtask

    task automatic ledBarTest();
        int e0;
        e0 = errors;
        foreach (sampleSet[k]) begin
            for (int i = 0; i < 5; i++) begin
                runFrame(sampleSet[k]);
            end
            checkLeds("leds", thermoCode(refLevel), leds);
        end
        reportTest("led bar", e0);
    endtask

    task automatic darkPhase(input sample_t v, input int frames, input logic expDark);
        for (int i = 0; i < frames; i++) begin
            runFrame(v);
        end
        checkBit("dark", expDark, dark);
    endtask

    task automatic hysteresisTest();
        int e0;
        e0 = errors;
        darkPhase(8'd20, 12, 1'b1);
        darkPhase(8'd50, 6, 1'b1);
        darkPhase(8'd80, 6, 1'b0);
        darkPhase(8'd50, 6, 1'b0);
        darkPhase(8'd20, 6, 1'b1);
        reportTest("dark hysteresis", e0);
    endtask

    task automatic randomTest();
        int          e0;
        logic [31:0] r;
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            r = nextRandom();
            runFrame(r[7:0]);
        end
        reportTest("random samples", e0);
    endtask

    initial begin
        rstN        = 1'b0;
        sensorValue = '0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        rngState    = 32'd55;
        refAcc      = 0;
        refPrimed   = 1'b0;
        refLevel    = '0;
        refDark     = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        resetValuesTest();
        frameFormatTest();
        averagingTest();
        ledBarTest();
        hysteresisTest();
        randomTest();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== test/alsSensorModel.sv ====
// alsSensorModel: behavioural serial light sensor that answers each frame on sdo
`timescale 1ns/1ns

module alsSensorModel import alsPkg::*; (
    input  logic    cs,
    input  logic    sck,
    input  sample_t value,
    output logic    sdo
);

    localparam int FrameLen = PREFIX_TICKS + DATA_TICKS + POSTFIX_TICKS;

    logic [FrameLen-1:0] frame     = '0;
    int unsigned         fallTotal = 0;
    int unsigned         fallBase  = 0;
    int unsigned         steps;
    logic [FrameLen-1:0] shifted;

    // value is frozen for the whole frame
    always @(negedge cs) begin
        frame    <= {{PREFIX_TICKS{1'b0}}, value, {POSTFIX_TICKS{1'b0}}};
        fallBase <= fallTotal;
    end

    always @(negedge sck) begin
        fallTotal <= fallTotal + 1;
    end

    // first bit stays up until the fall after the first rise in the frame
    always_comb begin
        steps   = fallTotal - fallBase;
        shifted = (steps > 1) ? (frame << (steps - 1)) : frame;
        sdo     = cs ? 1'b0 : shifted[FrameLen-1];
    end

endmodule

// ==== hw/alsMonitorTop.sv ====
// alsMonitorTop: ambient light monitor with sampler, smoother and LED/alarm monitor
`timescale 1ns/1ns

module alsMonitorTop import alsPkg::*; #(
    parameter int QUERY_DELAY = 40,
    parameter int AVG_SHIFT   = 2,
    parameter int DARK_ON     = 40,
    parameter int DARK_OFF    = 60,
    parameter int LED_COUNT   = 8
) (
    input  logic                 clk,
    input  logic                 rstN,
    output logic                 cs,
    output logic                 sck,
    input  logic                 sdo,
    output sample_t              level,
    output logic [LED_COUNT-1:0] leds,
    output logic                 dark
);

    sample_t sample;
    logic    sampleValid;
    logic    levelValid;

    alsSampler #(
        .QUERY_DELAY (QUERY_DELAY)
    ) samplerInst (
        .clk         (clk),
        .rstN        (rstN),
        .cs          (cs),
        .sck         (sck),
        .sdo         (sdo),
        .sample      (sample),
        .sampleValid (sampleValid)
    );

    lightSmoother #(
        .AVG_SHIFT (AVG_SHIFT)
    ) smootherInst (
        .clk         (clk),
        .rstN        (rstN),
        .sample      (sample),
        .sampleValid (sampleValid),
        .level       (level),
        .levelValid  (levelValid)
    );

    lightMonitor #(
        .LED_COUNT (LED_COUNT),
        .DARK_ON   (DARK_ON),
        .DARK_OFF  (DARK_OFF)
    ) monitorInst (
        .clk        (clk),
        .rstN       (rstN),
        .level      (level),
        .levelValid (levelValid),
        .leds       (leds),
        .dark       (dark)
    );

endmodule

// ==== hw/lightMonitor.sv ====
// lightMonitor: thermometer LED bar and darkness alarm with hysteresis
`timescale 1ns/1ns

module lightMonitor import alsPkg::*; #(
    parameter int LED_COUNT = 8,
    parameter int DARK_ON   = 40,
    parameter int DARK_OFF  = 60
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  sample_t              level,
    input  logic                 levelValid,
    output logic [LED_COUNT-1:0] leds,
    output logic                 dark
);

    logic [LED_COUNT-1:0] ledsNext;
    alarmState_t          alarm;
    alarmState_t          alarmNext;

    // led i lit at (i+1)/LED_COUNT of full scale
    always_comb begin
        for (int i = 0; i < LED_COUNT; i++) begin
            ledsNext[i] = (int'(level) >= ((i + 1) * 256) / LED_COUNT);
        end
    end

    always_comb begin
        alarmNext = alarm;
        case (alarm)
            LIT: begin
                if (int'(level) < DARK_ON) begin
                    alarmNext = DARK;
                end
            end
            DARK: begin
                if (int'(level) >= DARK_OFF) begin
                    alarmNext = LIT;
                end
            end
            default: alarmNext = LIT;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            leds  <= '0;
            alarm <= LIT;
        end else if (levelValid) begin
            leds  <= ledsNext;
            alarm <= alarmNext;
        end
    end

    assign dark = (alarm == DARK);

endmodule

// ==== hw/lightSmoother.sv ====
// lightSmoother: exponential running average of the light samples
`timescale 1ns/1ns

module lightSmoother import alsPkg::*; #(
    parameter int AVG_SHIFT = 2
) (
    input  logic    clk,
    input  logic    rstN,
    input  sample_t sample,
    input  logic    sampleValid,
    output sample_t level,
    output logic    levelValid
);

    localparam int AccW = 8 + AVG_SHIFT;

    logic [AccW-1:0] acc;
    logic            primed;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            acc        <= '0;
            primed     <= 1'b0;
            levelValid <= 1'b0;
        end else begin
            levelValid <= sampleValid;
            if (sampleValid) begin
                primed <= 1'b1;
                if (!primed) begin
                    // first sample loads straight in
                    acc <= AccW'(sample) << AVG_SHIFT;
                end else begin
                    acc <= acc - (acc >> AVG_SHIFT) + AccW'(sample);
                end
            end
        end
    end

    assign level = acc[AccW-1:AVG_SHIFT];

endmodule

// ==== hw/alsSampler.sv ====
// alsSampler: frame sequencer for the light sensor, chip select and data shift
`timescale 1ns/1ns

module alsSampler import alsPkg::*; #(
    parameter int QUERY_DELAY = 40
) (
    input  logic    clk,
    input  logic    rstN,
    output logic    cs,
    output logic    sck,
    input  logic    sdo,
    output sample_t sample,
    output logic    sampleValid
);

    // counter must hold the idle gap and the longest frame phase
    localparam int CntMax = (QUERY_DELAY > DATA_TICKS) ? QUERY_DELAY : DATA_TICKS;
    localparam int CntW   = $clog2(CntMax + 1);

    logic            sckTick;
    frameState_t     state;
    frameState_t     stateNext;
    logic [CntW-1:0] cnt;
    logic            phaseEnd;
    logic            lastBit;
    sample_t         shiftReg;

    sckGen sckGenInst (
        .clk     (clk),
        .rstN    (rstN),
        .sck     (sck),
        .sckTick (sckTick)
    );

    // last tick of the current phase
    always_comb begin
        case (state)
            IDLE:    phaseEnd = (cnt == CntW'(QUERY_DELAY));
            PREFIX:  phaseEnd = (cnt == CntW'(PREFIX_TICKS - 1));
            DATA:    phaseEnd = (cnt == CntW'(DATA_TICKS - 1));
            POSTFIX: phaseEnd = (cnt == CntW'(POSTFIX_TICKS - 1));
            default: phaseEnd = 1'b1;
        endcase
    end

    always_comb begin
        stateNext = state;
        if (phaseEnd) begin
            case (state)
                IDLE:    stateNext = PREFIX;
                PREFIX:  stateNext = DATA;
                DATA:    stateNext = POSTFIX;
                default: stateNext = IDLE;
            endcase
        end
    end

    assign lastBit = (state == DATA) && phaseEnd;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= IDLE;
            cnt         <= '0;
            cs          <= 1'b1;
            sampleValid <= 1'b0;
        end else begin
            sampleValid <= sckTick && lastBit;
            if (sckTick) begin
                state <= stateNext;
                cnt   <= phaseEnd ? '0 : cnt + 1'b1;
                cs    <= (stateNext == IDLE);
            end
        end
    end

    // data bits come MSB first
    always_ff @(posedge clk) begin
        if (sckTick && state == DATA) begin
            shiftReg <= {shiftReg[6:0], sdo};
        end
        if (sckTick && lastBit) begin
            sample <= {shiftReg[6:0], sdo};
        end
    end

endmodule

// ==== hw/sckGen.sv ====
// sckGen: sensor clock divider with a one-cycle tick after each sck rise
`timescale 1ns/1ns

module sckGen import alsPkg::*; (
    input  logic clk,
    input  logic rstN,
    output logic sck,
    output logic sckTick
);

    // 8 low, 1 edge, 7 high
    localparam logic [2:0] DownLast = 3'd7;
    localparam logic [2:0] UpLast   = 3'd6;

    sckState_t  state;
    sckState_t  stateNext;
    logic [2:0] cnt;
    logic [2:0] cntNext;

    always_comb begin
        stateNext = state;
        cntNext   = cnt + 3'd1;
        case (state)
            DOWN: begin
                if (cnt == DownLast) begin
                    stateNext = EDGE;
                    cntNext   = '0;
                end
            end
            EDGE: begin
                stateNext = UP;
                cntNext   = '0;
            end
            UP: begin
                if (cnt == UpLast) begin
                    stateNext = DOWN;
                    cntNext   = '0;
                end
            end
            default: begin
                stateNext = DOWN;
                cntNext   = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= DOWN;
            cnt   <= '0;
            sck   <= 1'b0;
        end else begin
            state <= stateNext;
            cnt   <= cntNext;
            // from next state, so sck is a clean flop output
            sck   <= (stateNext != DOWN);
        end
    end

    assign sckTick = (state == EDGE);

endmodule

// ==== hw/alsPkg.sv ====
// sample type, FSM state enums and sensor frame phase lengths
package alsPkg;

    // light value as read from the sensor
    typedef logic [7:0] sample_t;

    // sampler frame phases
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        PREFIX  = 2'd1,
        DATA    = 2'd2,
        POSTFIX = 2'd3
    } frameState_t;

    // serial clock divider phases
    typedef enum logic [1:0] {
        DOWN = 2'd0,
        EDGE = 2'd1,
        UP   = 2'd2
    } sckState_t;

    // darkness alarm
    typedef enum logic {
        LIT  = 1'b0,
        DARK = 1'b1
    } alarmState_t;

    // frame layout in sampling ticks, fixed by the sensor
    localparam int PREFIX_TICKS  = 3;
    localparam int DATA_TICKS    = 8;
    localparam int POSTFIX_TICKS = 7;

endpackage
